// ==== Makefile ====
# Verilator build and run for the memory bank selector

VERILATOR ?= verilator
TOP       ?= tb_mem_select
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST)) src/mem_bank_macros.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
+incdir+src
src/mem_bank_pkg.sv
src/bank_port_if.sv
src/bank_ram.sv
src/bank_select.sv
src/mem_select_top.sv
sim/tb_clock_gen.sv
sim/tb_mem_select.sv

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
  // clock period in ns
  parameter int period       = 4,
  // rising edges seen with reset high
  parameter int reset_cycles = 8
) (
  output logic clk2,
  output logic reset
);

  // free running clock, starts low
  initial begin
    clk2 = 1'b0;
    forever #(period / 2) clk2 = ~clk2;
  end

  // synchronous reset, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk2);
    @(negedge clk2);
    reset = 1'b0;
  end

endmodule

// ==== sim/tb_mem_select.sv ====
`timescale 1ns/1ns
`include "mem_bank_macros.svh"

module tb_mem_select
  import mem_bank_pkg::*;
();

  ////////////////////////////////////////
  // clock, dut and run length
  ////////////////////////////////////////

  localparam int clk_period = 4;
  // reset 9, reset_zero 4, isolation 36, override 16,
  // invalid banks 28, burst 38, collision 5, plus slack
  localparam int run_cycles = 160;

  logic       clk2;
  logic       reset;
  bank_sel_t  top_mem_sel;
  logic       mem_sel_override;
  bank_sel_t  rd_q_sel;
  bank_sel_t  wt_q_sel;
  logic       wea;
  ram_addr_t  addra;
  ram_addr_t  addrb;
  half_word_t dina_high;
  half_word_t dina_low;
  ram_word_t  doutb;

  integer     seed;
  int         errors;
  int         tests_run;

  // reference contents indexed by bank number and address
  ram_word_t  sb [16][`MEM_DEPTH];

  tb_clock_gen #(
    .period       (clk_period),
    .reset_cycles (8)
  ) u_clock_gen (
    .clk2  (clk2),
    .reset (reset)
  );

  mem_select_top u_dut (
    .clk2             (clk2),
    .reset            (reset),
    .top_mem_sel      (top_mem_sel),
    .mem_sel_override (mem_sel_override),
    .rd_q_sel         (rd_q_sel),
    .wt_q_sel         (wt_q_sel),
    .wea              (wea),
    .addra            (addra),
    .dina_high        (dina_high),
    .dina_low         (dina_low),
    .addrb            (addrb),
    .doutb            (doutb)
  );

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // override takes both queue selectors
  function automatic bank_sel_t pick_bank(input bank_sel_t q_sel);
    return mem_sel_override ? top_mem_sel : q_sel;
  endfunction

  // only banks 1..9 exist
  function automatic logic bank_exists(input bank_sel_t b);
    return (b >= bank_sel_t'(`MEM_FIRST_BANK)) &&
           (b < bank_sel_t'(`MEM_FIRST_BANK + `MEM_NUM_BANKS));
  endfunction

  function automatic ram_word_t model_read(input bank_sel_t b, input ram_addr_t a);
    if (bank_exists(b)) begin
      return sb[b][a];
    end
    return '0;
  endfunction

  // a write to a missing bank is lost
  task automatic model_write(input bank_sel_t b, input ram_addr_t a, input ram_word_t w);
    if (bank_exists(b)) begin
      sb[b][a] = w;
    end
  endtask

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  function automatic ram_word_t rand_word();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[`MEM_WORD_W-1:0];
  endfunction

  function automatic bank_sel_t rand_bank();
    logic [31:0] r;
    r = $random(seed);
    return bank_sel_t'(r % 32'd9 + 32'd1);
  endfunction

  function automatic ram_addr_t rand_addr();
    logic [31:0] r;
    r = $random(seed);
    return r[`MEM_ADDR_W-1:0];
  endfunction

  // one write through port A with wea dropped on the next falling edge
  task automatic write_word(input bank_sel_t sel, input ram_addr_t a, input ram_word_t w);
    @(negedge clk2);
    wt_q_sel  = sel;
    wea       = 1'b1;
    addra     = a;
    dina_high = w[`MEM_WORD_W-1:`MEM_HALF_W];
    dina_low  = w[`MEM_HALF_W-1:0];
    model_write(pick_bank(sel), a, w);
    @(negedge clk2);
    wea = 1'b0;
  endtask

  task automatic check_word(input ram_word_t got, input ram_word_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  // single read checked one cycle later
  task automatic read_expect(input bank_sel_t sel, input ram_addr_t a, input string what);
    ram_word_t exp;
    @(negedge clk2);
    rd_q_sel = sel;
    addrb    = a;
    exp      = model_read(pick_bank(sel), a);
    @(negedge clk2);
    check_word(doutb, exp, what);
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - err_before);
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  // read bank register is cleared, so the mux gives zero
  task automatic reset_zero();
    int e0;
    e0 = errors;
    repeat (4) begin
      @(negedge clk2);
      check_word(doutb, '0, "doutb after reset");
    end
    report_test("reset_zero", e0);
  endtask

  // same address in every bank with different words
  task automatic bank_isolation();
    int e0;
    e0 = errors;
    for (int b = 1; b <= 9; b++) begin
      write_word(bank_sel_t'(b), 11'h155, rand_word());
    end
    for (int b = 1; b <= 9; b++) begin
      read_expect(bank_sel_t'(b), 11'h155, "bank isolation read");
    end
    report_test("bank_isolation", e0);
  endtask

  task automatic override_select();
    int e0;
    e0 = errors;
    // known words in banks 2 and 7 first
    write_word(4'd2, 11'h020, rand_word());
    write_word(4'd7, 11'h020, rand_word());
    @(negedge clk2);
    mem_sel_override = 1'b1;
    top_mem_sel      = 4'd5;
    // queue selectors point elsewhere, bank 5 takes both
    write_word(4'd2, 11'h020, rand_word());
    read_expect(4'd7, 11'h020, "override read");
    @(negedge clk2);
    mem_sel_override = 1'b0;
    read_expect(4'd7, 11'h020, "bank 7 after override");
    read_expect(4'd2, 11'h020, "bank 2 after override");
    read_expect(4'd5, 11'h020, "bank 5 after override");
    report_test("override_select", e0);
  endtask

  // indices 0 and 10..15 have no storage
  task automatic invalid_banks();
    int e0;
    e0 = errors;
    write_word(4'd0, 11'h155, rand_word());
    write_word(4'd12, 11'h155, rand_word());
    for (int b = 1; b <= 9; b++) begin
      read_expect(bank_sel_t'(b), 11'h155, "bank unchanged by lost write");
    end
    read_expect(4'd0, 11'h155, "read of bank 0");
    read_expect(4'd10, 11'h155, "read of bank 10");
    read_expect(4'd15, 11'h155, "read of bank 15");
    report_test("invalid_banks", e0);
  endtask

  // new read every cycle with each checked on the following cycle
  task automatic read_burst();
    bank_sel_t bq[$];
    ram_addr_t aq[$];
    ram_word_t exp_prev;
    bank_sel_t b;
    ram_addr_t a;
    int        e0;
    e0 = errors;
    for (int i = 0; i < 12; i++) begin
      b = rand_bank();
      a = rand_addr();
      write_word(b, a, rand_word());
      bq.push_back(b);
      aq.push_back(a);
      // one empty slot in the middle of the burst
      if (i == 5) begin
        bq.push_back(4'd11);
        aq.push_back(a);
      end
    end
    for (int i = 0; i <= bq.size(); i++) begin
      @(negedge clk2);
      if (i < bq.size()) begin
        rd_q_sel = bq[i];
        addrb    = aq[i];
      end
      // previous word must hold while the next read is already presented
      #(clk_period / 4);
      if (i > 0) begin
        check_word(doutb, exp_prev, "burst read");
      end
      if (i < bq.size()) begin
        exp_prev = model_read(pick_bank(bq[i]), aq[i]);
      end
    end
    report_test("read_burst", e0);
  endtask

  // read-first on a same-address collision
  task automatic read_write_collision();
    ram_word_t new_w;
    ram_word_t exp_old;
    int        e0;
    e0 = errors;
    write_word(4'd3, 11'h03a, rand_word());
    new_w = rand_word();
    @(negedge clk2);
    wt_q_sel  = 4'd3;
    wea       = 1'b1;
    addra     = 11'h03a;
    dina_high = new_w[`MEM_WORD_W-1:`MEM_HALF_W];
    dina_low  = new_w[`MEM_HALF_W-1:0];
    rd_q_sel  = 4'd3;
    addrb     = 11'h03a;
    exp_old   = model_read(4'd3, 11'h03a);
    model_write(4'd3, 11'h03a, new_w);
    @(negedge clk2);
    wea = 1'b0;
    check_word(doutb, exp_old, "collision returns old word");
    // address still driven so the next edge reads the new word
    @(negedge clk2);
    check_word(doutb, model_read(4'd3, 11'h03a), "read after collision");
    report_test("read_write_collision", e0);
  endtask

  ////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    seed             = 23;
    errors           = 0;
    tests_run        = 0;
    top_mem_sel      = '0;
    mem_sel_override = 1'b0;
    rd_q_sel         = '0;
    wt_q_sel         = '0;
    wea              = 1'b0;
    addra            = '0;
    addrb            = '0;
    dina_high        = '0;
    dina_low         = '0;
    @(negedge reset);
    reset_zero();
    bank_isolation();
    override_select();
    invalid_banks();
    read_burst();
    read_write_collision();
    $display("tests run %0d, errors %0d", tests_run, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // twice the expected run length
  initial begin
    #(run_cycles * clk_period * 2);
    $display("watchdog expired, the tests did not finish in time");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== src/bank_port_if.sv ====
`timescale 1ns/1ns
`include "mem_bank_macros.svh"

interface bank_port_if
  import mem_bank_pkg::*;
();

  // one write strobe per bank, at most one high in a cycle
  logic [`MEM_NUM_BANKS-1:0] we;

  // port A address and data, shared by all banks
  ram_addr_t addra;
  ram_word_t dina;

  // port B address, shared by all banks
  ram_addr_t addrb;

  // registered read word of every bank
  // element k belongs to bank k + MEM_FIRST_BANK
  ram_word_t doutb [`MEM_NUM_BANKS];

  // selector side
  modport sel (
    output we,
    output addra,
    output addrb,
    output dina,
    input  doutb
  );

  // bank side
  modport bank (
    input  we,
    input  addra,
    input  addrb,
    input  dina,
    output doutb
  );

endinterface

// ==== src/bank_ram.sv ====
`timescale 1ns/1ns
`include "mem_bank_macros.svh"

module bank_ram
  import mem_bank_pkg::*;
#(
  // element of the we and doutb arrays that this bank owns
  parameter int bank_idx = 0
) (
  input logic       clk2,
  bank_port_if.bank bp
);

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  // queue words, no reset on the contents
  ram_word_t mem [`MEM_DEPTH];

  // port B output register
  ram_word_t rd_q;

  ////////////////////////////////////////
  // port A write
  ////////////////////////////////////////

  // only the bank picked by the selector sees its strobe high
  always_ff @(posedge clk2) begin
    if (bp.we[bank_idx]) begin
      mem[bp.addra] <= bp.dina;
    end
  end

  ////////////////////////////////////////
  // port B read
  ////////////////////////////////////////

  // read every cycle whether or not this bank is picked
  // the selector decides later which bank output is used
  // nonblocking update gives read-first on an address collision
  always_ff @(posedge clk2) begin
    rd_q <= mem[bp.addrb];
  end

  // hand the registered word to our slot in the interface
  assign bp.doutb[bank_idx] = rd_q;

endmodule

// ==== src/bank_select.sv ====
`timescale 1ns/1ns
`include "mem_bank_macros.svh"

module bank_select
  import mem_bank_pkg::*;
(
  input  logic       clk2,
  input  logic       reset,

  // bank choice
  input  bank_sel_t  top_mem_sel,
  input  logic       mem_sel_override,
  input  bank_sel_t  rd_q_sel,
  input  bank_sel_t  wt_q_sel,

  // port A
  input  logic       wea,
  input  ram_addr_t  addra,
  input  half_word_t dina_high,
  input  half_word_t dina_low,

  // port B
  input  ram_addr_t  addrb,
  output ram_word_t  doutb,

  // towards the banks
  bank_port_if.sel   bp
);

  // effective bank numbers after the override
  bank_sel_t wt_bank;
  bank_sel_t rd_bank;

  // read bank lined up with the bank output register
  bank_sel_t rd_bank_q;

  // write bank falls inside the populated range
  logic      wt_valid;

  ////////////////////////////////////////
  // override
  ////////////////////////////////////////

  // top level may take over both queue selectors at once
  assign wt_bank = mem_sel_override ? top_mem_sel : wt_q_sel;
  assign rd_bank = mem_sel_override ? top_mem_sel : rd_q_sel;

  assign wt_valid = (wt_bank >= bank_sel_t'(`MEM_FIRST_BANK)) &&
                    (wt_bank <  bank_sel_t'(`MEM_FIRST_BANK + `MEM_NUM_BANKS));

  ////////////////////////////////////////
  // write side
  ////////////////////////////////////////

  // one-hot decode of the write bank
  // an index outside 1..9 matches no slot, so the write is dropped
  always_comb begin
    for (int k = 0; k < `MEM_NUM_BANKS; k++) begin
      bp.we[k] = wea && (wt_bank == bank_sel_t'(k + `MEM_FIRST_BANK));
    end
  end

  // shared address and data for every bank
  assign bp.addra = addra;
  assign bp.dina  = {dina_high, dina_low};

  ////////////////////////////////////////
  // read side
  ////////////////////////////////////////

  // all banks read the same address, the mux picks one afterwards
  assign bp.addrb = addrb;

  // bank data shows up one edge after the address
  // so the bank number is held for the same edge
  always_ff @(posedge clk2) begin
    if (reset) begin
      rd_bank_q <= '0;
    end else begin
      rd_bank_q <= rd_bank;
    end
  end

  // output mux, zero for any index with no bank behind it
  // this also keeps doutb at zero after reset until the first read
  always_comb begin
    doutb = '0;
    for (int k = 0; k < `MEM_NUM_BANKS; k++) begin
      if (rd_bank_q == bank_sel_t'(k + `MEM_FIRST_BANK)) begin
        doutb = bp.doutb[k];
      end
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // never two banks written by the same strobe
  a_we_onehot0 : assert property (
    @(posedge clk2) disable iff (reset)
    $onehot0(bp.we)
  );

  // a strobe aimed at a real bank is never lost
  a_we_hit : assert property (
    @(posedge clk2) disable iff (reset)
    (wea && wt_valid) |-> $onehot(bp.we)
  );

endmodule

// ==== src/mem_bank_macros.svh ====
`ifndef MEM_BANK_MACROS_SVH
`define MEM_BANK_MACROS_SVH

// bank count and numbering
// banks are numbered from MEM_FIRST_BANK upward
`define MEM_NUM_BANKS  9
`define MEM_FIRST_BANK 1

// words held by one bank
`define MEM_DEPTH      2048

// address width follows the depth, log2 of 2048
`define MEM_ADDR_W     11

// stored word and the two halves it is built from
`define MEM_WORD_W     60
`define MEM_HALF_W     30

// bank index width, room for 16 codes of which 9 are used
`define MEM_SEL_W      4

`endif

// ==== src/mem_bank_pkg.sv ====
`include "mem_bank_macros.svh"

package mem_bank_pkg;

  ////////////////////////////////////////
  // bank selection
  ////////////////////////////////////////

  // bank number as seen on the selector inputs
  // codes 0 and 10..15 point at no bank
  typedef logic [`MEM_SEL_W-1:0] bank_sel_t;

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  // word address inside one bank
  typedef logic [`MEM_ADDR_W-1:0] ram_addr_t;

  // one queue entry as stored in a bank
  typedef logic [`MEM_WORD_W-1:0] ram_word_t;

  // write data arrives split in two halves
  // high half lands in the upper bits of ram_word_t
  typedef logic [`MEM_HALF_W-1:0] half_word_t;

endpackage

// ==== src/mem_select_top.sv ====
`timescale 1ns/1ns
`include "mem_bank_macros.svh"

module mem_select_top
  import mem_bank_pkg::*;
(
  input  logic       clk2,
  input  logic       reset,

  // bank choice from the top level and the two queues
  input  bank_sel_t  top_mem_sel,
  input  logic       mem_sel_override,
  input  bank_sel_t  rd_q_sel,
  input  bank_sel_t  wt_q_sel,

  // write port
  input  logic       wea,
  input  ram_addr_t  addra,
  input  half_word_t dina_high,
  input  half_word_t dina_low,

  // read port, one cycle latency
  input  ram_addr_t  addrb,
  output ram_word_t  doutb
);

  ////////////////////////////////////////
  // selector to bank bundle
  ////////////////////////////////////////

  bank_port_if u_bp ();

  ////////////////////////////////////////
  // bank selection
  ////////////////////////////////////////

  bank_select u_bank_select (
    .clk2             (clk2),
    .reset            (reset),
    .top_mem_sel      (top_mem_sel),
    .mem_sel_override (mem_sel_override),
    .rd_q_sel         (rd_q_sel),
    .wt_q_sel         (wt_q_sel),
    .wea              (wea),
    .addra            (addra),
    .dina_high        (dina_high),
    .dina_low         (dina_low),
    .addrb            (addrb),
    .doutb            (doutb),
    .bp               (u_bp.sel)
  );

  ////////////////////////////////////////
  // ram banks
  ////////////////////////////////////////

  // slot k holds bank number k + MEM_FIRST_BANK
  // bank index 0 has no storage behind it
  for (genvar k = 0; k < `MEM_NUM_BANKS; k++) begin : u_bank
    bank_ram #(
      .bank_idx (k)
    ) u_ram (
      .clk2 (clk2),
      .bp   (u_bp.bank)
    );
  end

endmodule
